// File: arb_mem_top.f
hw/arb_mem_pkg.sv
hw/strobe_gen.sv
hw/rr_arbiter.sv
hw/client_port.sv
hw/shared_ram.sv
hw/arb_mem_top.sv
testbench/tb_clock_gen.sv
testbench/arb_mem_assertions.sv
testbench/tb_arb_mem_top.sv

// File: hw/arb_mem_pkg.sv
`default_nettype none

package arb_mem_pkg;

    // ----------------------------------------------------------------------
    // widths with a meaning
    // ----------------------------------------------------------------------

    // word address into the shared memory
    localparam int addr_w = 8;

    // one memory data word
    localparam int data_w = 16;

    typedef logic [addr_w - 1:0] addr_t;

    typedef logic [data_w - 1:0] data_t;

    // word count follows the address width
    localparam int mem_depth = 2 ** $bits(addr_t);

    // ----------------------------------------------------------------------
    // access kinds
    // ----------------------------------------------------------------------

    // value carried on a write strobe
    // low means read
    localparam logic op_read  = 1'b0;
    localparam logic op_write = 1'b1;

endpackage

`default_nettype wire

// File: hw/arb_mem_top.sv
`default_nettype none

module arb_mem_top
# (
    parameter int n_clients     = 4,
    parameter int strobe_period = 3
)
(
    input  wire                                    clk,
    input  wire                                    arst_n,

    // per-client command ports
    input  wire                [n_clients - 1:0]   cmd_valid,
    output logic               [n_clients - 1:0]   cmd_ready,
    input  wire                [n_clients - 1:0]   cmd_write,
    input  arb_mem_pkg::addr_t [n_clients - 1:0]   cmd_addr,
    input  arb_mem_pkg::data_t [n_clients - 1:0]   cmd_wdata,

    // per-client response ports
    output logic               [n_clients - 1:0]   rsp_valid,
    input  wire                [n_clients - 1:0]   rsp_ready,
    output arb_mem_pkg::data_t [n_clients - 1:0]   rsp_rdata
);

    // ----------------------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------------------

    logic                                  ena;
    logic               [n_clients - 1:0]  req;
    logic               [n_clients - 1:0]  gnt;

    // per-client memory commands
    logic               [n_clients - 1:0]  mem_write;
    arb_mem_pkg::addr_t [n_clients - 1:0]  mem_addr;
    arb_mem_pkg::data_t [n_clients - 1:0]  mem_wdata;

    // shared read bus
    arb_mem_pkg::data_t                    rdata;

    // ----------------------------------------------------------------------
    // pacing and arbitration
    // ----------------------------------------------------------------------

    strobe_gen
    # (.strobe_period (strobe_period))
    u_strobe
    (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .strobe ( ena    )
    );

    rr_arbiter
    # (.n_clients (n_clients))
    u_arbiter
    (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .ena    ( ena    ),
        .req    ( req    ),
        .gnt    ( gnt    )
    );

    shared_ram
    # (.n_clients (n_clients))
    u_ram
    (
        .clk      ( clk       ),
        .gnt      ( gnt       ),
        .op_write ( mem_write ),
        .op_addr  ( mem_addr  ),
        .op_wdata ( mem_wdata ),
        .rdata    ( rdata     )
    );

    // ----------------------------------------------------------------------
    // client ports
    // ----------------------------------------------------------------------

    // every client sees the same rdata
    // only the one in wait_data keeps it
    for (genvar i = 0; i < n_clients; i++)
    begin : g_client
        client_port u_client
        (
            .clk       ( clk          ),
            .arst_n    ( arst_n       ),
            .cmd_valid ( cmd_valid[i] ),
            .cmd_ready ( cmd_ready[i] ),
            .cmd_write ( cmd_write[i] ),
            .cmd_addr  ( cmd_addr[i]  ),
            .cmd_wdata ( cmd_wdata[i] ),
            .rsp_valid ( rsp_valid[i] ),
            .rsp_ready ( rsp_ready[i] ),
            .rsp_rdata ( rsp_rdata[i] ),
            .req       ( req[i]       ),
            .gnt       ( gnt[i]       ),
            .mem_write ( mem_write[i] ),
            .mem_addr  ( mem_addr[i]  ),
            .mem_wdata ( mem_wdata[i] ),
            .mem_rdata ( rdata        )
        );
    end

endmodule

`default_nettype wire

// File: hw/client_port.sv
`default_nettype none

module client_port
(
    input  wire                 clk,
    input  wire                 arst_n,

    // command from outside
    input  wire                 cmd_valid,
    output logic                cmd_ready,
    input  wire                 cmd_write,
    input  arb_mem_pkg::addr_t  cmd_addr,
    input  arb_mem_pkg::data_t  cmd_wdata,

    // response to outside
    output logic                rsp_valid,
    input  wire                 rsp_ready,
    output arb_mem_pkg::data_t  rsp_rdata,

    // arbiter side
    output logic                req,
    input  wire                 gnt,

    // memory side
    output logic                mem_write,
    output arb_mem_pkg::addr_t  mem_addr,
    output arb_mem_pkg::data_t  mem_wdata,
    input  arb_mem_pkg::data_t  mem_rdata
);

    typedef enum logic [1:0]
    {
        st_idle,
        st_wait_gnt,
        st_wait_data,
        st_respond
    } state_t;

    state_t state;
    state_t state_nx;

    // latched command
    logic               write_q;
    arb_mem_pkg::addr_t addr_q;
    arb_mem_pkg::data_t wdata_q;

    // captured read word
    arb_mem_pkg::data_t rdata_q;

    logic accept;

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------

    assign accept = cmd_valid && cmd_ready;

    always_comb
    begin
        state_nx = state;
        case (state)
            st_idle:      if (accept)    state_nx = st_wait_gnt;
            st_wait_gnt:  if (gnt)       state_nx = st_wait_data;
            // memory word is on mem_rdata now
            st_wait_data:                state_nx = st_respond;
            st_respond:   if (rsp_ready) state_nx = st_idle;
            default:                     state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= st_idle;
        else
            state <= state_nx;
    end

    // ----------------------------------------------------------------------
    // payload
    // ----------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            write_q <= cmd_write;
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
        end
        // write responses capture a meaningless word too
        if (state == st_wait_data)
            rdata_q <= mem_rdata;
    end

    // handshake outputs straight from state
    assign cmd_ready = (state == st_idle);
    assign req       = (state == st_wait_gnt);
    assign rsp_valid = (state == st_respond);
    assign rsp_rdata = rdata_q;

    // memory only looks at these in our gnt cycle
    assign mem_write = write_q;
    assign mem_addr  = addr_q;
    assign mem_wdata = wdata_q;

endmodule

`default_nettype wire

// File: hw/rr_arbiter.sv
`default_nettype none

module rr_arbiter
# (
    parameter int n_clients = 4
)
(
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    ena,
    input  wire  [n_clients - 1:0] req,
    output logic [n_clients - 1:0] gnt
);

    // one-hot pointer to the last grantee
    logic [n_clients - 1:0] ptr;

    // request and choice in rotated order
    logic [n_clients - 1:0] req_rot;
    logic [n_clients - 1:0] pick_rot;

    // choice back in client order
    logic [n_clients - 1:0] pick;

    // index of the last grantee and of the top-priority slot
    int last_idx;
    int start;

    // index arithmetic modulo n_clients
    function automatic int wrap(input int v);
        return (v >= n_clients) ? v - n_clients : v;
    endfunction

    // ----------------------------------------------------------------------
    // rotate, pick, rotate back
    // ----------------------------------------------------------------------

    // encode the one-hot pointer
    always_comb
    begin
        last_idx = 0;
        for (int i = 0; i < n_clients; i++)
        begin
            if (ptr[i])
                last_idx = i;
        end
        start = wrap(last_idx + 1);
    end

    // slot after last grantee goes to position zero
    always_comb
    begin
        for (int k = 0; k < n_clients; k++)
            req_rot[k] = req[wrap(start + k)];
    end

    // fixed priority on the rotated vector
    // lowest set bit wins
    assign pick_rot = req_rot & (~req_rot + 1'b1);

    always_comb
    begin
        pick = '0;
        for (int k = 0; k < n_clients; k++)
            pick[wrap(start + k)] = pick_rot[k];
    end

    // ----------------------------------------------------------------------
    // grant register
    // ----------------------------------------------------------------------

    // decisions only on strobe cycles
    // gnt drops again on the following cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            gnt <= '0;
            // client 0 first after reset
            ptr <= {1'b1, {(n_clients - 1){1'b0}}};
        end
        else if (ena)
        begin
            gnt <= pick;
            if (|req)
                ptr <= pick;
        end
        else
        begin
            gnt <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/shared_ram.sv
`default_nettype none

module shared_ram
# (
    parameter int n_clients = 4
)
(
    input  wire                                       clk,
    input  wire                   [n_clients - 1:0]   gnt,
    input  wire                   [n_clients - 1:0]   op_write,
    input  arb_mem_pkg::addr_t    [n_clients - 1:0]   op_addr,
    input  arb_mem_pkg::data_t    [n_clients - 1:0]   op_wdata,
    output arb_mem_pkg::data_t                        rdata
);

    arb_mem_pkg::data_t mem [arb_mem_pkg::mem_depth];

    // command of the granted client
    logic               sel_valid;
    logic               sel_write;
    arb_mem_pkg::addr_t sel_addr;
    arb_mem_pkg::data_t sel_wdata;

    // ----------------------------------------------------------------------
    // command mux
    // ----------------------------------------------------------------------

    // gnt is one-hot so at most one match
    always_comb
    begin
        sel_write = arb_mem_pkg::op_read;
        sel_addr  = '0;
        sel_wdata = '0;
        for (int i = 0; i < n_clients; i++)
        begin
            if (gnt[i])
            begin
                sel_write = op_write[i];
                sel_addr  = op_addr[i];
                sel_wdata = op_wdata[i];
            end
        end
    end

    assign sel_valid = |gnt;

    // ----------------------------------------------------------------------
    // single port array
    // ----------------------------------------------------------------------

    // read word shows up the cycle after gnt
    always_ff @(posedge clk)
    begin
        if (sel_valid)
        begin
            if (sel_write == arb_mem_pkg::op_write)
                mem[sel_addr] <= sel_wdata;
            else
                rdata <= mem[sel_addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/strobe_gen.sv
`default_nettype none

module strobe_gen
# (
    parameter int strobe_period = 3
)
(
    input  wire  clk,
    input  wire  arst_n,
    output logic strobe
);

    // counter just wide enough for strobe_period - 1
    localparam int cnt_w = $clog2(strobe_period);

    logic [cnt_w - 1:0] cnt;

    // ----------------------------------------------------------------------
    // down-counter with reload
    // ----------------------------------------------------------------------

    // first pulse lands strobe_period clocks after reset release
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt    <= cnt_w'(strobe_period - 1);
            strobe <= 1'b0;
        end
        else if (cnt == '0)
        begin
            // reload and fire one pulse
            cnt    <= cnt_w'(strobe_period - 1);
            strobe <= 1'b1;
        end
        else
        begin
            cnt    <= cnt - 1'b1;
            strobe <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the arbitrated memory testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_arb_mem_top \
    -f arb_mem_top.f \
    -o sim_tb

# the exit status of tee is kept so that the log is always checked
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: testbench/arb_mem_assertions.sv
`default_nettype none

module arb_mem_assertions
# (
    parameter int n_clients = 4
)
(
    input wire                   clk,
    input wire                   arst_n,
    input wire                   ena,
    input wire [n_clients - 1:0] req,
    input wire [n_clients - 1:0] gnt
);

    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------------------------------------
    // grant properties
    // ----------------------------------------------------------------------

    // never two grants at once
    gnt_onehot : assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(gnt))
        else $error("gnt has more than one bit set: %b", gnt);

    // grants only follow a strobe
    gnt_after_ena : assert property (@(posedge clk) disable iff (!arst_n)
        (gnt != '0) |-> $past(ena))
        else $error("gnt %b issued without a strobe in the prior cycle", gnt);

    // granted client was asking
    gnt_was_req : assert property (@(posedge clk) disable iff (!arst_n)
        (gnt != '0) |-> (($past(req) & gnt) == gnt))
        else $error("gnt %b given to a client without a request", gnt);

endmodule

bind rr_arbiter arb_mem_assertions
# (.n_clients (n_clients))
u_arb_checks
(
    .clk    ( clk    ),
    .arst_n ( arst_n ),
    .ena    ( ena    ),
    .req    ( req    ),
    .gnt    ( gnt    )
);

`default_nettype wire

// File: testbench/tb_arb_mem_top.sv
`default_nettype none

module tb_arb_mem_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_clients      = 4;
    localparam int strobe_period  = 3;
    localparam int timeout_cycles = 300;

    logic clk;
    logic arst_n;

    logic               [n_clients - 1:0] cmd_valid;
    logic               [n_clients - 1:0] cmd_ready;
    logic               [n_clients - 1:0] cmd_write;
    arb_mem_pkg::addr_t [n_clients - 1:0] cmd_addr;
    arb_mem_pkg::data_t [n_clients - 1:0] cmd_wdata;
    logic               [n_clients - 1:0] rsp_valid;
    logic               [n_clients - 1:0] rsp_ready;
    arb_mem_pkg::data_t [n_clients - 1:0] rsp_rdata;

    // ----------------------------------------------------------------------
    // reference model state
    // ----------------------------------------------------------------------

    arb_mem_pkg::data_t     shadow [arb_mem_pkg::mem_depth];
    logic                   cur_write [n_clients];
    arb_mem_pkg::addr_t     cur_addr [n_clients];
    arb_mem_pkg::data_t     cur_wdata [n_clients];
    arb_mem_pkg::data_t     held_data [n_clients];
    int                     resp_count [n_clients];
    logic [n_clients - 1:0] pending;
    logic [n_clients - 1:0] prev_valid;
    logic [n_clients - 1:0] prev_ready;
    // model of the arbiter pointer, client 0 first after reset
    int                     last_served;
    int                     last_rise;
    int                     cycle;
    logic                   check_order;
    int                     seed;

    tb_clock_gen u_clk
    (
        .clk    ( clk    ),
        .arst_n ( arst_n )
    );

    arb_mem_top
    # (
        .n_clients     ( n_clients     ),
        .strobe_period ( strobe_period )
    )
    u_dut
    (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cmd_valid ( cmd_valid ),
        .cmd_ready ( cmd_ready ),
        .cmd_write ( cmd_write ),
        .cmd_addr  ( cmd_addr  ),
        .cmd_wdata ( cmd_wdata ),
        .rsp_valid ( rsp_valid ),
        .rsp_ready ( rsp_ready ),
        .rsp_rdata ( rsp_rdata )
    );

    // ----------------------------------------------------------------------
    // error exits
    // ----------------------------------------------------------------------

    task automatic stop_failed();
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        $display("CHECK FAILED: %s expected %0h actual %0h", name, exp, act);
        stop_failed();
    endtask

    task automatic fail_text(input string what);
        $display("ERROR: %s", what);
        stop_failed();
    endtask

    // ----------------------------------------------------------------------
    // reference functions
    // ----------------------------------------------------------------------

    // first pending client after the last one served, wrapping
    function automatic int next_grant(input logic [n_clients - 1:0] pend, input int last);
        int idx;
        for (int k = 1; k <= n_clients; k++)
        begin
            idx = (last + k) % n_clients;
            if (pend[idx])
                return idx;
        end
        return -1;
    endfunction

    function automatic arb_mem_pkg::data_t expected_read(input arb_mem_pkg::addr_t a);
        return shadow[a];
    endfunction

    // every address bit shows up in the word
    function automatic arb_mem_pkg::data_t fill_word(input arb_mem_pkg::addr_t a);
        return {a ^ 8'h3c, ~a};
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic arb_mem_pkg::addr_t random_addr();
        return arb_mem_pkg::addr_t'($random(seed));
    endfunction

    function automatic arb_mem_pkg::data_t random_data();
        return arb_mem_pkg::data_t'($random(seed));
    endfunction

    // ----------------------------------------------------------------------
    // comparing process
    // ----------------------------------------------------------------------

    always @(posedge clk)
        cycle = cycle + 1;

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin : compare
        int exp_c;
        if (arst_n)
        begin
            for (int c = 0; c < n_clients; c++)
            begin
                if (rsp_valid[c] && !prev_valid[c])
                begin
                    // new response marks the order of service
                    if (check_order)
                    begin
                        exp_c = next_grant(pending, last_served);
                        assert (c == exp_c)
                        else
                            fail_value("service order", exp_c, c);
                    end
                    assert (cycle - last_rise >= strobe_period)
                    else
                        fail_value("strobe spacing", strobe_period, cycle - last_rise);
                    last_rise   = cycle;
                    last_served = c;
                    pending[c]  = 1'b0;
                    held_data[c] = rsp_rdata[c];
                    if (!cur_write[c])
                    begin
                        assert (rsp_rdata[c] == expected_read(cur_addr[c]))
                        else
                            fail_value("read data", expected_read(cur_addr[c]), rsp_rdata[c]);
                    end
                end
                else if (rsp_valid[c])
                begin
                    assert (rsp_rdata[c] == held_data[c])
                    else
                        fail_value("held rsp_rdata", held_data[c], rsp_rdata[c]);
                end
                assert (!(prev_valid[c] && !rsp_valid[c] && !prev_ready[c]))
                else
                    fail_text("rsp_valid dropped before the handshake");
                if (rsp_valid[c])
                begin
                    assert (!cmd_ready[c])
                    else
                        fail_text("cmd_ready high while a response is pending");
                end
                // handshake completes at the coming edge
                if (rsp_valid[c] && rsp_ready[c])
                begin
                    if (cur_write[c])
                        shadow[cur_addr[c]] = cur_wdata[c];
                    resp_count[c]++;
                end
                prev_valid[c] = rsp_valid[c];
                prev_ready[c] = rsp_ready[c];
            end
        end
    end

    // ----------------------------------------------------------------------
    // driver tasks, entered 2 ns after a rising edge
    // ----------------------------------------------------------------------

    task automatic issue(input int c, input logic wr, input arb_mem_pkg::addr_t a,
                         input arb_mem_pkg::data_t d);
        int t;
        t = 0;
        // cmd_ready comes from state, stable until the next edge
        while (!cmd_ready[c])
        begin
            @(posedge clk);
            #2;
            t++;
            if (t > timeout_cycles)
                fail_text($sformatf("client %0d never became ready", c));
        end
        cmd_valid[c] = 1'b1;
        cmd_write[c] = wr;
        cmd_addr[c]  = a;
        cmd_wdata[c] = d;
        @(posedge clk);
        cur_write[c] = wr;
        cur_addr[c]  = a;
        cur_wdata[c] = d;
        pending[c]   = 1'b1;
        #2;
        cmd_valid[c] = 1'b0;
    endtask

    task automatic wait_response(input int c, input int n);
        int t;
        t = 0;
        while (resp_count[c] < n)
        begin
            @(posedge clk);
            #2;
            t++;
            if (t > timeout_cycles)
                fail_text($sformatf("client %0d response never completed", c));
        end
    endtask

    task automatic do_access(input int c, input logic wr, input arb_mem_pkg::addr_t a,
                             input arb_mem_pkg::data_t d);
        int n;
        n = resp_count[c] + 1;
        issue(c, wr, a, d);
        wait_response(c, n);
    endtask

    // each client owns the addresses with its index in the low bits
    task automatic fill_part(input int c);
        arb_mem_pkg::addr_t a;
        for (int k = 0; k < arb_mem_pkg::mem_depth / n_clients; k++)
        begin
            a = arb_mem_pkg::addr_t'(k * n_clients + c);
            do_access(c, 1'b1, a, fill_word(a));
        end
    endtask

    task automatic run_round(input logic [n_clients - 1:0] mask);
        fork
            if (mask[0]) do_access(0, 1'b0, random_addr(), '0);
            if (mask[1]) do_access(1, 1'b0, random_addr(), '0);
            if (mask[2]) do_access(2, 1'b0, random_addr(), '0);
            if (mask[3]) do_access(3, 1'b0, random_addr(), '0);
        join
    endtask

    task automatic run_random(input int c, input int n);
        arb_mem_pkg::addr_t a;
        int gap;
        for (int k = 0; k < n; k++)
        begin
            gap = rand_below(3);
            repeat (gap)
            begin
                @(posedge clk);
                #2;
            end
            a      = random_addr();
            a[1:0] = 2'(c);
            do_access(c, rand_below(2) == 1, a, random_data());
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    initial
    begin
        int t;
        int hold;
        int n1;
        int n_ops [n_clients];
        logic [n_clients - 1:0] mask;
        arb_mem_pkg::addr_t wr_addr [8];

        cmd_valid   = '0;
        cmd_write   = '0;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        rsp_ready   = '1;
        pending     = '0;
        prev_valid  = '0;
        prev_ready  = '0;
        last_served = n_clients - 1;
        last_rise   = -1000;
        cycle       = 0;
        check_order = 1'b0;
        seed        = 32'hdec6;
        for (int c = 0; c < n_clients; c++)
        begin
            resp_count[c] = 0;
            cur_write[c]  = 1'b0;
            n_ops[c]      = 0;
        end

        t = 0;
        while (arst_n !== 1'b1)
        begin
            @(posedge clk);
            t++;
            if (t > 10)
                fail_text("reset was never released");
        end

        // idle handshake state right after reset
        for (int i = 0; i < 3; i++)
        begin
            @(negedge clk);
            assert (cmd_ready == '1)
            else
                fail_value("reset cmd_ready", 4'hf, cmd_ready);
            assert (rsp_valid == '0)
            else
                fail_value("reset rsp_valid", 0, rsp_valid);
        end
        @(posedge clk);
        #2;

        // known contents everywhere
        fork
            fill_part(0);
            fill_part(1);
            fill_part(2);
            fill_part(3);
        join

        // single client write then read back
        for (int i = 0; i < 8; i++)
        begin
            wr_addr[i] = random_addr();
            do_access(0, 1'b1, wr_addr[i], random_data());
        end
        for (int i = 0; i < 8; i++)
            do_access(0, 1'b0, wr_addr[i], '0);

        // rotation, full contention first
        check_order = 1'b1;
        for (int r = 0; r < 6; r++)
        begin
            mask = (r < 3) ? '1 : 4'(rand_below(15) + 1);
            run_round(mask);
        end
        check_order = 1'b0;

        // client 1 stalls its response
        rsp_ready[1] = 1'b0;
        n1 = resp_count[1] + 1;
        fork
            do_access(0, 1'b0, random_addr(), '0);
            issue(1, 1'b0, random_addr(), '0);
            do_access(2, 1'b0, random_addr(), '0);
            do_access(3, 1'b0, random_addr(), '0);
        join
        t = 0;
        while (!rsp_valid[1])
        begin
            @(posedge clk);
            #2;
            t++;
            if (t > timeout_cycles)
                fail_text("client 1 never presented its response");
        end
        hold = 4 + rand_below(12);
        repeat (hold) @(posedge clk);
        #2;
        rsp_ready[1] = 1'b1;
        wait_response(1, n1);

        // random traffic spread over random clients
        for (int i = 0; i < 200; i++)
            n_ops[rand_below(n_clients)]++;
        fork
            run_random(0, n_ops[0]);
            run_random(1, n_ops[1]);
            run_random(2, n_ops[2]);
            run_random(3, n_ops[3]);
        join

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
# (
    parameter int half_period_ns = 20,
    parameter int reset_cycles   = 2
)
(
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // free running clock
    initial
    begin
        clk = 1'b0;
        forever
            #(half_period_ns) clk = ~clk;
    end

    // reset low for the first cycles, released off the edge
    initial
    begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire
